// ==== project.f ====
+incdir+.
rv_isa_pkg.sv
rv_bus_pkg.sv
rv_fetch.sv
rv_decoder.sv
rv_register_file.sv
rv_alu.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_rv_core || exit 1
out="$(./obj_dir/Vtb_rv_core)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1

// ==== tb_rv_core.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module tb_rv_core;
  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  localparam int PROG_MAX = 128;
  localparam logic [6:0] CODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] CODE_LOAD = 7'b0000011;
  localparam logic [6:0] CODE_JALR = 7'b1100111;

  typedef struct packed {
    rv_addr_t addr;
    rv_word_t data;
  } store_t;
  typedef store_t store_q_t[$];

  logic     clk;
  logic     reset;
  rv_addr_t imem_addr;
  rv_word_t imem_data;
  wb_req_t  wb_req;
  wb_rsp_t  wb_rsp;

  rv_word_t imem [PROG_MAX];
  int       prog_len;
  rv_addr_t halt_pc;
  logic     prog_ready = 1'b0;
  store_q_t expected;
  int       seed = 4782;
  int       addr_errors = 0;
  int       data_errors = 0;
  int       flag_errors = 0;
  int       store_errors = 0;

  rv_core dut_i (
    .clk      (clk),
    .reset    (reset),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp)
  );

  // instruction memory is a plain combinational read
  assign imem_data = imem[imem_addr[8:2]];

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic rv_word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                      input rv_reg_idx_t rd, input rv_reg_idx_t rs1,
                                      input rv_reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv_word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                      input rv_reg_idx_t rd, input rv_reg_idx_t rs1,
                                      input rv_word_t imm);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic rv_word_t s_type(input rv_reg_idx_t rs1, input rv_reg_idx_t rs2,
                                      input rv_word_t imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv_word_t b_type(input logic [2:0] f3, input rv_reg_idx_t rs1,
                                      input rv_reg_idx_t rs2, input rv_word_t imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv_word_t u_type(input rv_reg_idx_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic rv_word_t j_type(input rv_reg_idx_t rd, input rv_word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic rv_word_t fill_word(input rv_addr_t a);
    return ~a ^ 32'h3C5A_0000;
  endfunction

  task automatic emit(input rv_word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // result in x4, stored at x10 + off
  task automatic r_and_store(input logic [6:0] f7, input logic [2:0] f3,
                             input rv_reg_idx_t rs1, input rv_reg_idx_t rs2,
                             input rv_word_t off);
    emit(r_type(f7, f3, 5'd4, rs1, rs2));
    emit(s_type(5'd10, 5'd4, off));
  endtask

  // result in x5
  task automatic i_and_store(input logic [2:0] f3, input rv_reg_idx_t rs1,
                             input rv_word_t imm, input rv_word_t off);
    emit(i_type(CODE_OP_IMM, f3, 5'd5, rs1, imm));
    emit(s_type(5'd10, 5'd5, off));
  endtask

  task automatic build_program();
    for (int i = 0; i < PROG_MAX; i++) begin
      imem[i] = 32'h0000_0013;
    end
    prog_len = 0;
    emit(i_type(CODE_OP_IMM, 3'd0, 5'd1, 5'd0, -5));
    emit(i_type(CODE_OP_IMM, 3'd0, 5'd10, 5'd0, 256));
    emit(u_type(5'd2, 20'h12345));
    emit(i_type(CODE_OP_IMM, 3'd0, 5'd2, 5'd2, 32'h678));
    emit(i_type(CODE_OP_IMM, 3'd0, 5'd3, 5'd0, 7));
    r_and_store(7'h00, 3'd0, 5'd1, 5'd2, 0);
    r_and_store(7'h20, 3'd0, 5'd1, 5'd2, 4);
    r_and_store(7'h00, 3'd1, 5'd2, 5'd3, 8);
    r_and_store(7'h00, 3'd2, 5'd1, 5'd2, 12);
    r_and_store(7'h00, 3'd3, 5'd1, 5'd2, 16);
    r_and_store(7'h00, 3'd4, 5'd1, 5'd2, 20);
    r_and_store(7'h00, 3'd5, 5'd1, 5'd3, 24);
    r_and_store(7'h20, 3'd5, 5'd1, 5'd3, 28);
    r_and_store(7'h00, 3'd6, 5'd1, 5'd2, 32);
    r_and_store(7'h00, 3'd7, 5'd1, 5'd2, 36);
    i_and_store(3'd0, 5'd2, -1, 40);
    i_and_store(3'd2, 5'd1, -4, 44);
    i_and_store(3'd3, 5'd3, -1, 48);
    i_and_store(3'd4, 5'd2, -256, 52);
    i_and_store(3'd6, 5'd1, 32'h0F0, 56);
    i_and_store(3'd7, 5'd2, -16, 60);
    i_and_store(3'd1, 5'd1, 4, 64);
    i_and_store(3'd5, 5'd1, 28, 68);
    i_and_store(3'd5, 5'd1, 32'h402, 72);
    // load back earlier results and store them again
    emit(i_type(CODE_LOAD, 3'd2, 5'd6, 5'd10, 4));
    emit(s_type(5'd10, 5'd6, 76));
    emit(i_type(CODE_LOAD, 3'd2, 5'd7, 5'd10, 0));
    emit(r_type(7'h00, 3'd0, 5'd7, 5'd7, 5'd6));
    emit(s_type(5'd10, 5'd7, 80));
    // beq taken, bne not taken, bne taken, beq not taken
    emit(b_type(3'b000, 5'd3, 5'd3, 8));
    emit(s_type(5'd10, 5'd1, 84));
    emit(b_type(3'b001, 5'd3, 5'd3, 8));
    emit(s_type(5'd10, 5'd2, 88));
    emit(b_type(3'b001, 5'd1, 5'd3, 8));
    emit(s_type(5'd10, 5'd3, 92));
    emit(b_type(3'b000, 5'd1, 5'd3, 8));
    emit(s_type(5'd10, 5'd3, 96));
    emit(j_type(5'd8, 8));
    emit(s_type(5'd10, 5'd1, 100));
    emit(s_type(5'd10, 5'd8, 104));
    // jalr target is three words past the addi, odd offset gets bit 0 cleared
    emit(i_type(CODE_OP_IMM, 3'd0, 5'd9, 5'd0, rv_word_t'(prog_len * 4 + 12)));
    emit(i_type(CODE_JALR, 3'd0, 5'd11, 5'd9, 1));
    emit(s_type(5'd10, 5'd1, 108));
    emit(s_type(5'd10, 5'd11, 112));
    emit(i_type(CODE_OP_IMM, 3'd0, 5'd0, 5'd0, 55));
    emit(s_type(5'd10, 5'd0, 116));
    halt_pc = rv_addr_t'(prog_len * 4);
    emit(j_type(5'd0, 0));
  endtask

  function automatic rv_word_t alu_ref(input logic [2:0] f3, input logic alt,
                                       input rv_word_t a, input rv_word_t b);
    case (f3)
      3'd0: begin
        if (alt) return a - b;
        return a + b;
      end
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return rv_word_t'($signed(a) >>> b[4:0]);
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // ISA model, runs until the pc repeats
  function automatic store_q_t rv_model_run();
    store_q_t   stores;
    store_t     st;
    rv_word_t   x [32];
    rv_word_t   mem [256];
    rv_addr_t   pc;
    rv_addr_t   next_pc;
    rv_addr_t   ea;
    rv_word_t   ins;
    rv_word_t   rs1_val;
    rv_word_t   rs2_val;
    rv_word_t   imm_i;
    rv_word_t   imm_s;
    rv_word_t   imm_b;
    rv_word_t   imm_j;
    rv_word_t   rd_val;
    logic       rd_write;
    logic [2:0] f3;
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(rv_addr_t'(i * 4));
    end
    pc = `RV_RESET_PC;
    for (int step = 0; step < 4 * PROG_MAX; step++) begin
      ins = imem[pc[8:2]];
      f3 = ins[14:12];
      rs1_val = x[ins[19:15]];
      rs2_val = x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      rd_write = 1'b1;
      rd_val = '0;
      next_pc = pc + 4;
      case (ins[6:0])
        7'b0110011: rd_val = alu_ref(f3, ins[30], rs1_val, rs2_val);
        7'b0010011: rd_val = alu_ref(f3, ins[30] && f3 == 3'b101, rs1_val, imm_i);
        7'b0110111: rd_val = {ins[31:12], 12'b0};
        7'b0000011: begin
          ea = rs1_val + imm_i;
          rd_val = mem[ea[9:2]];
        end
        7'b0100011: begin
          rd_write = 1'b0;
          ea = rs1_val + imm_s;
          mem[ea[9:2]] = rs2_val;
          st.addr = ea;
          st.data = rs2_val;
          stores.push_back(st);
        end
        7'b1101111: begin
          rd_val = pc + 4;
          next_pc = pc + imm_j;
        end
        7'b1100111: begin
          rd_val = pc + 4;
          ea = rs1_val + imm_i;
          next_pc = {ea[31:1], 1'b0};
        end
        7'b1100011: begin
          rd_write = 1'b0;
          if ((rs1_val == rs2_val) != f3[0]) next_pc = pc + imm_b;
        end
        default: rd_write = 1'b0;
      endcase
      if (rd_write && ins[11:7] != 5'd0) x[ins[11:7]] = rd_val;
      if (next_pc == pc) break;
      pc = next_pc;
    end
    return stores;
  endfunction

  task automatic check_addr(input string name, input rv_addr_t actual, input rv_addr_t exp_val);
    if (actual !== exp_val) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, exp_val);
      addr_errors++;
    end
  endtask

  task automatic check_data(input string name, input rv_word_t actual, input rv_word_t exp_val);
    if (actual !== exp_val) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, exp_val);
      data_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic exp_val);
    if (actual !== exp_val) begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, actual, exp_val);
      flag_errors++;
    end
  endtask

  // wishbone slave with 0 to 3 wait states
  initial begin : bus_model
    rv_word_t ram [256];
    int       wait_left;
    logic     pending;
    for (int i = 0; i < 256; i++) begin
      ram[i] = fill_word(rv_addr_t'(i * 4));
    end
    wb_rsp = '0;
    pending = 1'b0;
    wait_left = 0;
    forever begin
      @(posedge clk);
      #2;
      if (wb_rsp.ack) begin
        wb_rsp = '0;
        pending = 1'b0;
      end else if (wb_req.cyc && wb_req.stb) begin
        if (!pending) begin
          pending = 1'b1;
          wait_left = $unsigned($random(seed)) % 4;
        end
        if (wait_left == 0) begin
          wb_rsp.ack = 1'b1;
          if (wb_req.we) ram[wb_req.adr[9:2]] = wb_req.dat;
          else wb_rsp.dat = ram[wb_req.adr[9:2]];
        end else begin
          wait_left--;
        end
      end
    end
  end

  // ack is already up half a cycle before the ack edge
  always @(negedge clk) begin : store_monitor
    store_t exp_store;
    if (!reset && wb_req.cyc && wb_req.stb && wb_req.we && wb_rsp.ack) begin
      if (expected.size() == 0) begin
        $display("extra store at %0t ns to address %h was not predicted", $time, wb_req.adr);
        store_errors++;
      end else begin
        exp_store = expected.pop_front();
        check_addr("wb_req.adr", wb_req.adr, exp_store.addr);
        check_data("wb_req.dat", wb_req.dat, exp_store.data);
      end
    end
  end

  initial begin : watchdog
    wait (prog_ready);
    #(prog_len * 5 * 40 + 2000);
    $display("timeout: the core never reached the halt loop at %h", halt_pc);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main
    int total;
    reset = 1'b1;
    build_program();
    expected = rv_model_run();
    $display("program of %0d words, %0d stores predicted", prog_len, expected.size());
    prog_ready = 1'b1;
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      #2;
      check_flag("wb_req.cyc", wb_req.cyc, 1'b0);
      check_flag("wb_req.stb", wb_req.stb, 1'b0);
      check_addr("imem_addr", imem_addr, `RV_RESET_PC);
    end
    reset = 1'b0;
    @(negedge clk);
    check_addr("imem_addr", imem_addr, `RV_RESET_PC);
    check_flag("wb_req.cyc", wb_req.cyc, 1'b0);
    check_flag("wb_req.stb", wb_req.stb, 1'b0);
    @(negedge clk);
    check_addr("imem_addr", imem_addr, rv_addr_t'(`RV_RESET_PC + 4));
    while (imem_addr !== halt_pc) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
    if (expected.size() != 0) begin
      $display("%0d predicted stores never appeared on the bus", expected.size());
      store_errors += expected.size();
    end
    total = addr_errors + data_errors + flag_errors + store_errors;
    $display("errors: address %0d, data %0d, flag %0d, store count %0d",
             addr_errors, data_errors, flag_errors, store_errors);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_core (
  input  logic                 clk,
  input  logic                 reset,
  output rv_isa_pkg::rv_addr_t imem_addr,
  input  rv_isa_pkg::rv_word_t imem_data,
  output rv_bus_pkg::wb_req_t  wb_req,
  input  rv_bus_pkg::wb_rsp_t  wb_rsp
);
  import rv_isa_pkg::*;

  rv_decoded_t dec;
  rv_addr_t    pc;
  rv_addr_t    pc_plus_4;
  rv_word_t    rs1_data;
  rv_word_t    rs2_data;
  rv_word_t    alu_b;
  rv_word_t    alu_result;
  logic        alu_zero;
  rv_word_t    load_data;
  rv_word_t    write_data;
  logic        stall;

  assign imem_addr = pc;

  rv_fetch fetch_i (
    .clk       (clk),
    .reset     (reset),
    .dec       (dec),
    .alu_zero  (alu_zero),
    .alu_result(alu_result),
    .stall     (stall),
    .pc        (pc),
    .pc_plus_4 (pc_plus_4)
  );

  rv_decoder decoder_i (
    .instr(imem_data),
    .dec  (dec)
  );

  rv_register_file register_file_i (
    .clk         (clk),
    .reset       (reset),
    .rs1         (dec.rs1),
    .rs2         (dec.rs2),
    .rd          (dec.rd),
    .write_enable(dec.reg_write && !stall),
    .write_data  (write_data),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data)
  );

  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  rv_alu alu_i (
    .a     (rs1_data),
    .b     (alu_b),
    .op    (dec.alu_op),
    .result(alu_result),
    .zero  (alu_zero)
  );

  // address comes from rs1 + imm through the alu
  rv_lsu lsu_i (
    .clk       (clk),
    .reset     (reset),
    .dec       (dec),
    .addr      (alu_result),
    .store_data(rs2_data),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .stall     (stall),
    .load_data (load_data)
  );

  always_comb begin
    case (dec.wb_sel)
      WB_MEM:  write_data = load_data;
      WB_LINK: write_data = pc_plus_4;
      default: write_data = alu_result;
    endcase
  end

endmodule

// ==== rv_lsu.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_lsu (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_isa_pkg::rv_decoded_t dec,
  input  rv_isa_pkg::rv_addr_t    addr,
  input  rv_isa_pkg::rv_word_t    store_data,
  output rv_bus_pkg::wb_req_t     wb_req,
  input  rv_bus_pkg::wb_rsp_t     wb_rsp,
  output logic                    stall,
  output rv_isa_pkg::rv_word_t    load_data
);
  import rv_isa_pkg::*;

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_BUS,
    LSU_DONE
  } lsu_state_e;

  lsu_state_e state;
  logic       mem_op;
  logic       req_we;
  rv_addr_t   req_adr;
  rv_word_t   req_dat;

  assign mem_op = dec.is_load || dec.is_store;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= LSU_IDLE;
    end else begin
      case (state)
        LSU_IDLE: if (mem_op) state <= LSU_BUS;
        LSU_BUS:  if (wb_rsp.ack) state <= LSU_DONE;
        default:  state <= LSU_IDLE;
      endcase
    end
  end

  // request is latched once, so it stays put until ack
  always_ff @(posedge clk) begin
    if (state == LSU_IDLE && mem_op) begin
      req_we  <= dec.is_store;
      req_adr <= addr;
      req_dat <= store_data;
    end
    if (state == LSU_BUS && wb_rsp.ack) begin
      load_data <= wb_rsp.dat;
    end
  end

  assign wb_req = '{
    cyc: (state == LSU_BUS),
    stb: (state == LSU_BUS),
    we:  req_we,
    adr: req_adr,
    dat: req_dat
  };

  // retire happens in DONE, one cycle after ack
  assign stall = mem_op && (state != LSU_DONE);

  // the stalled pc keeps the memory instruction in decode
  bus_holds_instr_a: assert property (@(posedge clk) disable iff (reset)
    wb_req.cyc |-> mem_op);

  req_stable_a: assert property (@(posedge clk) disable iff (reset)
    wb_req.cyc && !wb_rsp.ack |=> $stable(wb_req));

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_alu (
  input  rv_isa_pkg::rv_word_t   a,
  input  rv_isa_pkg::rv_word_t   b,
  input  rv_isa_pkg::rv_alu_op_e op,
  output rv_isa_pkg::rv_word_t   result,
  output logic                   zero
);
  import rv_isa_pkg::*;

  logic [$clog2(`RV_XLEN)-1:0] shamt;

  assign shamt = b[$clog2(`RV_XLEN)-1:0];

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = rv_word_t'($signed(a) < $signed(b));
      ALU_SLTU:   result = rv_word_t'(a < b);
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = rv_word_t'($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = a + b;
    endcase
  end

  // used by BEQ and BNE
  assign zero = (result == '0);

endmodule

// ==== rv_register_file.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_register_file (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_isa_pkg::rv_reg_idx_t rs1,
  input  rv_isa_pkg::rv_reg_idx_t rs2,
  input  rv_isa_pkg::rv_reg_idx_t rd,
  input  logic                    write_enable,
  input  rv_isa_pkg::rv_word_t    write_data,
  output rv_isa_pkg::rv_word_t    rs1_data,
  output rv_isa_pkg::rv_word_t    rs2_data
);
  import rv_isa_pkg::*;

  rv_word_t regs [`RV_REG_COUNT];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 is never written so it keeps its reset value
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && rd != '0) begin
      regs[rd] <= write_data;
    end
  end

  x0_zero_a: assert property (@(posedge clk) disable iff (reset)
    (rs1 == '0 |-> rs1_data == '0) and (rs2 == '0 |-> rs2_data == '0));

endmodule

// ==== rv_decoder.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_decoder (
  input  rv_isa_pkg::rv_word_t    instr,
  output rv_isa_pkg::rv_decoded_t dec
);
  import rv_isa_pkg::*;

  rv_word_t   imm_i;
  rv_word_t   imm_s;
  rv_word_t   imm_b;
  rv_word_t   imm_j;
  rv_word_t   imm_u;
  logic [2:0] funct3;
  logic       funct7_b5;

  function automatic rv_alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];

  // sign-extended immediates, one per format
  assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};
  assign imm_j = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    dec        = '0;
    dec.rs1    = instr[19:15];
    dec.rs2    = instr[24:20];
    dec.rd     = instr[11:7];
    dec.alu_op = ALU_ADD;
    dec.wb_sel = WB_ALU;
    case (instr[6:0])
      OPC_OP: begin
        dec.alu_op    = alu_op_of(funct3, funct7_b5);
        dec.reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        // only the right shift reads funct7 here, ADDI has no SUB form
        dec.alu_op    = alu_op_of(funct3, funct7_b5 && (funct3 == 3'b101));
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
      end
      OPC_LUI: begin
        dec.alu_op    = ALU_PASS_B;
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
      end
      OPC_LOAD: begin
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        dec.wb_sel    = WB_MEM;
        dec.is_load   = 1'b1;
      end
      OPC_STORE: begin
        dec.imm      = imm_s;
        dec.use_imm  = 1'b1;
        dec.is_store = 1'b1;
      end
      OPC_JAL: begin
        dec.imm       = imm_j;
        dec.reg_write = 1'b1;
        dec.wb_sel    = WB_LINK;
        dec.is_jal    = 1'b1;
      end
      OPC_JALR: begin
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        dec.wb_sel    = WB_LINK;
        dec.is_jalr   = 1'b1;
      end
      OPC_BRANCH: begin
        dec.alu_op    = ALU_SUB;
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
        dec.branch_ne = funct3[0];
      end
      default: begin
        // retires as a no-op
      end
    endcase
  end

endmodule

// ==== rv_fetch.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_fetch (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_isa_pkg::rv_decoded_t dec,
  input  logic                    alu_zero,
  input  rv_isa_pkg::rv_word_t    alu_result,
  input  logic                    stall,
  output rv_isa_pkg::rv_addr_t    pc,
  output rv_isa_pkg::rv_addr_t    pc_plus_4
);
  import rv_isa_pkg::*;

  rv_addr_t next_pc;
  logic     take_branch;

  assign pc_plus_4 = pc + rv_addr_t'(4);

  // branch compare comes from a SUB in the alu
  assign take_branch = dec.is_branch && (dec.branch_ne ? !alu_zero : alu_zero);

  always_comb begin
    if (dec.is_jalr) begin
      next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
    end else if (dec.is_jal || take_branch) begin
      next_pc = pc + dec.imm;
    end else begin
      next_pc = pc_plus_4;
    end
  end

  // pc holds while the lsu waits on the bus
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RV_RESET_PC;
    end else if (!stall) begin
      pc <= next_pc;
    end
  end

  pc_aligned_a: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== rv_bus_pkg.sv ====
package rv_bus_pkg;

  // wishbone classic, master to slave
  typedef struct packed {
    logic               cyc;
    logic               stb;
    logic               we;
    rv_isa_pkg::rv_addr_t adr;
    rv_isa_pkg::rv_word_t dat;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic               ack;
    rv_isa_pkg::rv_word_t dat;
  } wb_rsp_t;

endpackage

// ==== rv_isa_pkg.sv ====
`include "rv_config.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] rv_word_t;
  typedef logic [`RV_XLEN-1:0] rv_addr_t;
  typedef logic [$clog2(`RV_REG_COUNT)-1:0] rv_reg_idx_t;

  // major opcodes kept by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } rv_opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    // LUI result is the immediate itself
    ALU_PASS_B = 4'd10
  } rv_alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_MEM  = 2'd1,
    WB_LINK = 2'd2
  } rv_wb_sel_e;

  typedef struct packed {
    rv_reg_idx_t rs1;
    rv_reg_idx_t rs2;
    rv_reg_idx_t rd;
    rv_alu_op_e  alu_op;
    rv_word_t    imm;
    logic        use_imm;
    logic        reg_write;
    rv_wb_sel_e  wb_sel;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    // BNE when set, BEQ otherwise
    logic        branch_ne;
    logic        is_jal;
    logic        is_jalr;
  } rv_decoded_t;

endpackage

// ==== rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_REG_COUNT 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
